//--- coreDebugIf.sv
`timescale 1ns/1ps
`default_nettype none

// Run control and state inspection between debug unit and core
interface coreDebugIf import mipsPkg::*; ();

	// From the debug unit
	logic runEn;
	// One-cycle pulse, one instruction
	logic stepReq;
	logic [REG_ADDR_BITS-1:0] regAddr;

	// From the core
	// High at an instruction boundary only
	logic halted;
	logic [WORD_BITS-1:0] regData;
	logic [WORD_BITS-1:0] pc;

	modport core (input runEn, stepReq, regAddr, output halted, regData, pc);
	modport debug (output runEn, stepReq, regAddr, input halted, regData, pc);

endinterface

`default_nettype wire

//--- cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import mipsPkg::*, debugPkg::*; (
	input logic clk,
	input logic arstN,
	memBus.requester mem,
	coreDebugIf.core dbg
);

	// Stage names kept as FSM states
	localparam logic [2:0] S_HALT = 3'd0;
	localparam logic [2:0] S_FETCH = 3'd1;
	localparam logic [2:0] S_DECODE = 3'd2;
	localparam logic [2:0] S_EXECUTE = 3'd3;
	localparam logic [2:0] S_MEMORY = 3'd4;
	localparam logic [2:0] S_WRITEBACK = 3'd5;

	logic [2:0] state;
	logic [WORD_BITS-1:0] pc;
	logic [WORD_BITS-1:0] nextPc;
	logic [WORD_BITS-1:0] pcPlus4;
	instrWordU ir;
	logic [WORD_BITS-1:0] aVal;
	logic [WORD_BITS-1:0] bVal;
	logic [WORD_BITS-1:0] aluRes;
	logic [WORD_BITS-1:0] mdr;
	logic [WORD_BITS-1:0] immSext;
	logic [WORD_BITS-1:0] rf [2**REG_ADDR_BITS];
	logic [REG_ADDR_BITS-1:0] wrIdx;
	logic wrEn;
	logic reqQ;
	logic stepPrev;
	logic stepRise;
	// Stop after the current instruction
	logic stepMode;
	// Stopped on BREAK, wait for runEn to drop
	logic parked;
	logic isLoad;
	logic isStore;
	logic memDone;

	assign immSext = {{(WORD_BITS-16){ir.i.imm[15]}}, ir.i.imm};
	assign pcPlus4 = pc + 32'd4;
	assign isLoad = (ir.i.op == OP_LW);
	assign isStore = (ir.i.op == OP_SW);
	assign stepRise = dbg.stepReq && !stepPrev;
	assign memDone = reqQ && mem.ack;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= S_HALT;
			pc <= '0;
			reqQ <= 1'b0;
			stepPrev <= 1'b0;
			stepMode <= 1'b0;
			parked <= 1'b0;
		end else begin
			stepPrev <= dbg.stepReq;
			if (!dbg.runEn) begin
				parked <= 1'b0;
			end
			case (state)
				S_HALT: begin
					if (stepRise || (dbg.runEn && !parked)) begin
						stepMode <= stepRise;
						state <= S_FETCH;
					end
				end
				// Same handshake for fetch and data access
				S_FETCH, S_MEMORY: begin
					if (!reqQ && !mem.ack) begin
						reqQ <= 1'b1;
					end else if (memDone) begin
						reqQ <= 1'b0;
						state <= (state == S_FETCH) ? S_DECODE : S_WRITEBACK;
					end
				end
				S_DECODE: begin
					// BREAK leaves the PC on itself
					if (ir.r.op == OP_RTYPE && ir.r.funct == FN_BREAK) begin
						parked <= 1'b1;
						state <= S_HALT;
					end else begin
						state <= S_EXECUTE;
					end
				end
				S_EXECUTE: state <= (isLoad || isStore) ? S_MEMORY : S_WRITEBACK;
				S_WRITEBACK: begin
					pc <= nextPc;
					// Instruction boundary
					state <= (stepMode || !dbg.runEn) ? S_HALT : S_FETCH;
				end
				default: state <= S_HALT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath and register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		case (state)
			S_FETCH: if (memDone) ir <= mem.rdata;
			S_DECODE: begin
				// Register 0 reads zero
				aVal <= (ir.r.rs == '0) ? '0 : rf[ir.r.rs];
				bVal <= (ir.r.rt == '0) ? '0 : rf[ir.r.rt];
			end
			S_EXECUTE: begin
				aluRes <= aVal + immSext;
				wrEn <= 1'b0;
				wrIdx <= ir.i.rt;
				nextPc <= pcPlus4;
				case (ir.i.op)
					OP_RTYPE: begin
						wrIdx <= ir.r.rd;
						wrEn <= 1'b1;
						case (ir.r.funct)
							FN_ADDU: aluRes <= aVal + bVal;
							FN_SUBU: aluRes <= aVal - bVal;
							FN_AND: aluRes <= aVal & bVal;
							FN_OR: aluRes <= aVal | bVal;
							FN_SLT: aluRes <= {{(WORD_BITS-1){1'b0}},
								($signed(aVal) < $signed(bVal))};
							default: wrEn <= 1'b0;
						endcase
					end
					OP_ADDIU, OP_LW: wrEn <= 1'b1;
					// Offset counted in words from PC+4
					OP_BEQ: if (aVal == bVal) nextPc <= pcPlus4 + {immSext[WORD_BITS-3:0], 2'b00};
					default: ;
				endcase
			end
			S_MEMORY: if (memDone) mdr <= mem.rdata;
			S_WRITEBACK: begin
				if (wrEn && wrIdx != '0) begin
					rf[wrIdx] <= isLoad ? mdr : aluRes;
				end
			end
			default: ;
		endcase
	end

	// Fetch by PC, data by ALU address
	assign mem.req = reqQ;
	assign mem.we = (state == S_MEMORY) && isStore;
	assign mem.addr = (state == S_MEMORY) ? aluRes[ADDR_BITS-1:0] : pc[ADDR_BITS-1:0];
	assign mem.wdata = bVal;

	assign dbg.halted = (state == S_HALT);
	assign dbg.pc = pc;
	assign dbg.regData = (dbg.regAddr == '0) ? '0 : rf[dbg.regAddr];

endmodule

`default_nettype wire

//--- debugPkg.sv
`default_nettype none

package debugPkg;

	////////////////////////////////////////////////////////////
	// Host command port
	////////////////////////////////////////////////////////////

	// Byte address on the host port and on every memory channel
	localparam int ADDR_BITS = 16;
	// Width of the command opcode
	localparam int CMD_OP_BITS = 3;

	// Host commands
	typedef enum logic [CMD_OP_BITS-1:0] {
		// Memory access, word wide
		DBG_MEM_WRITE = 3'd0,
		DBG_MEM_READ  = 3'd1,
		// State inspection, register index in cmdAddr
		DBG_REG_READ  = 3'd2,
		DBG_PC_READ   = 3'd3,
		// Run control
		DBG_RUN       = 3'd4,
		DBG_HALT      = 3'd5,
		DBG_STEP      = 3'd6
	} dbgOpE;

endpackage

`default_nettype wire

//--- debugUnit.sv
`timescale 1ns/1ps
`default_nettype none

module debugUnit import mipsPkg::*, debugPkg::*; (
	input logic clk,
	input logic arstN,
	input logic cmdReq,
	input dbgOpE cmdOp,
	input logic [ADDR_BITS-1:0] cmdAddr,
	input logic [WORD_BITS-1:0] cmdData,
	output logic cmdAck,
	output logic [WORD_BITS-1:0] rspData,
	memBus.requester mem,
	coreDebugIf.debug core
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_MEM = 3'd1;
	localparam logic [2:0] S_READ = 3'd2;
	localparam logic [2:0] S_RUN_ARM = 3'd3;
	localparam logic [2:0] S_RUN_WAIT = 3'd4;
	localparam logic [2:0] S_STEP_LEAVE = 3'd5;
	localparam logic [2:0] S_HALT_WAIT = 3'd6;
	localparam logic [2:0] S_DONE = 3'd7;

	logic [2:0] state;
	dbgOpE opQ;
	logic [ADDR_BITS-1:0] addrQ;
	logic [WORD_BITS-1:0] dataQ;
	logic memReqQ;
	logic runEnQ;
	logic stepReqQ;

	// Command fields, held for the whole command
	always_ff @(posedge clk) begin
		if (state == S_IDLE && cmdReq) begin
			opQ <= cmdOp;
			addrQ <= cmdAddr;
			dataQ <= cmdData;
		end
	end

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= S_IDLE;
			cmdAck <= 1'b0;
			rspData <= '0;
			memReqQ <= 1'b0;
			runEnQ <= 1'b0;
			stepReqQ <= 1'b0;
		end else begin
			// Step pulse lasts one cycle
			stepReqQ <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmdReq) begin
						case (cmdOp)
							DBG_MEM_WRITE, DBG_MEM_READ: state <= S_MEM;
							DBG_REG_READ, DBG_PC_READ: state <= S_READ;
							DBG_RUN: begin
								// Drop runEn for a cycle so a core parked on BREAK restarts
								runEnQ <= !core.halted;
								state <= S_RUN_ARM;
							end
							DBG_HALT: begin
								runEnQ <= 1'b0;
								state <= S_HALT_WAIT;
							end
							DBG_STEP: begin
								stepReqQ <= 1'b1;
								state <= S_STEP_LEAVE;
							end
							default: begin
								cmdAck <= 1'b1;
								state <= S_DONE;
							end
						endcase
					end
				end
				S_MEM: begin
					// Wait out the previous ack before a new request
					if (!memReqQ && !mem.ack) begin
						memReqQ <= 1'b1;
					end else if (memReqQ && mem.ack) begin
						memReqQ <= 1'b0;
						rspData <= mem.rdata;
						cmdAck <= 1'b1;
						state <= S_DONE;
					end
				end
				S_READ: begin
					rspData <= (opQ == DBG_PC_READ) ? core.pc : core.regData;
					cmdAck <= 1'b1;
					state <= S_DONE;
				end
				S_RUN_ARM: begin
					runEnQ <= 1'b1;
					state <= S_RUN_WAIT;
				end
				S_RUN_WAIT: begin
					if (!core.halted) begin
						rspData <= core.pc;
						cmdAck <= 1'b1;
						state <= S_DONE;
					end
				end
				// Core must first leave halt before the boundary counts
				S_STEP_LEAVE: if (!core.halted) state <= S_HALT_WAIT;
				S_HALT_WAIT: begin
					if (core.halted) begin
						rspData <= core.pc;
						cmdAck <= 1'b1;
						state <= S_DONE;
					end
				end
				S_DONE: begin
					if (!cmdReq) begin
						cmdAck <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign mem.req = memReqQ;
	assign mem.we = (opQ == DBG_MEM_WRITE);
	assign mem.addr = addrQ;
	assign mem.wdata = dataQ;

	assign core.runEn = runEnQ;
	assign core.stepReq = stepReqQ;
	assign core.regAddr = addrQ[REG_ADDR_BITS-1:0];

endmodule

`default_nettype wire

//--- memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input logic clk,
	input logic arstN,
	memBus.responder dbgPort,
	memBus.responder corePort,
	memBus.requester memPort
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_GRANT_DBG = 2'd1;
	localparam logic [1:0] S_GRANT_CORE = 2'd2;

	logic [1:0] state;
	logic dbgOwns;
	logic coreOwns;

	assign dbgOwns = (state == S_GRANT_DBG);
	assign coreOwns = (state == S_GRANT_CORE);

	////////////////////////////////////////////////////////////
	// Grant FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					// Fixed priority, debug first
					if (dbgPort.req) begin
						state <= S_GRANT_DBG;
					end else if (corePort.req) begin
						state <= S_GRANT_CORE;
					end
				end
				// Hold until both handshake halves are back low
				S_GRANT_DBG: begin
					if (!dbgPort.req && !memPort.ack) begin
						state <= S_IDLE;
					end
				end
				S_GRANT_CORE: begin
					if (!corePort.req && !memPort.ack) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Steering
	////////////////////////////////////////////////////////////

	// Request side from the owner, idle drives nothing
	assign memPort.req = (dbgOwns && dbgPort.req) || (coreOwns && corePort.req);
	assign memPort.we = dbgOwns ? dbgPort.we : (coreOwns && corePort.we);
	assign memPort.addr = dbgOwns ? dbgPort.addr : (coreOwns ? corePort.addr : '0);
	assign memPort.wdata = dbgOwns ? dbgPort.wdata : (coreOwns ? corePort.wdata : '0);

	// Response only to the owner, a waiting side sees ack low
	assign dbgPort.ack = dbgOwns && memPort.ack;
	assign dbgPort.rdata = dbgOwns ? memPort.rdata : '0;
	assign corePort.ack = coreOwns && memPort.ack;
	assign corePort.rdata = coreOwns ? memPort.rdata : '0;

endmodule

`default_nettype wire

//--- memBus.sv
`timescale 1ns/1ps
`default_nettype none

// One four-phase memory channel
// req up with fields stable, ack up, req down, ack down
interface memBus import mipsPkg::*, debugPkg::*; ();

	// Driven by the requester
	logic req;
	logic we;
	// Byte address, low two bits unused
	logic [ADDR_BITS-1:0] addr;
	logic [WORD_BITS-1:0] wdata;

	// Driven by the responder
	logic [WORD_BITS-1:0] rdata;
	logic ack;

	modport requester (output req, we, addr, wdata, input rdata, ack);
	modport responder (input req, we, addr, wdata, output rdata, ack);

endinterface

`default_nettype wire

//--- mipsDebugTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDebugTb import mipsPkg::*, debugPkg::*; ();

	localparam int MEM_WORDS = 256;
	// Cycles per handshake wait
	localparam int CMD_TIMEOUT = 2000;
	// Cycles for a program to reach BREAK
	localparam int RUN_TIMEOUT = 20000;

	logic clk;
	logic arstN;
	logic cmdReq;
	dbgOpE cmdOp;
	logic [ADDR_BITS-1:0] cmdAddr;
	logic [WORD_BITS-1:0] cmdData;
	logic cmdAck;
	logic [WORD_BITS-1:0] rspData;
	logic halted;

	int checks = 0;
	int errors = 0;
	integer seed = 32'hb21a_ef62;

	// Reference state, memory mirrors every host write
	logic [WORD_BITS-1:0] refMem [MEM_WORDS];
	logic [WORD_BITS-1:0] refRegs [32];
	logic [WORD_BITS-1:0] refPc;

	tbClock #(.resetCycles(8)) clkGen (.clk(clk), .arstN(arstN));

	mipsDebugTop #(.memWords(MEM_WORDS)) DUT (
		.clk(clk),
		.arstN(arstN),
		.cmdReq(cmdReq),
		.cmdOp(cmdOp),
		.cmdAddr(cmdAddr),
		.cmdData(cmdData),
		.cmdAck(cmdAck),
		.rspData(rspData),
		.halted(halted)
	);

	////////////////////////////////////////////////////////////
	// Host port handshake rules
	////////////////////////////////////////////////////////////

	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN) $rose(cmdAck) |-> cmdReq)
		else begin
			errors++;
			$display("handshake error at %0t: cmdAck rose while cmdReq was low", $time);
		end

	ackHeld: assert property (@(posedge clk) disable iff (!arstN) cmdAck && cmdReq |=> cmdAck)
		else begin
			errors++;
			$display("handshake error at %0t: cmdAck fell before cmdReq", $time);
		end

	rspStable: assert property (@(posedge clk) disable iff (!arstN)
		cmdAck |=> !cmdAck || $stable(rspData))
		else begin
			errors++;
			$display("handshake error at %0t: rspData changed while cmdAck was high", $time);
		end

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////

	task automatic finishRun();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic timedOut(input string what);
		errors++;
		$display("timeout at %0t: %s", $time, what);
		finishRun();
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host commands
	////////////////////////////////////////////////////////////

	// One four-phase command, response sampled while ack is high
	task automatic hostCmd(input dbgOpE op, input logic [15:0] addr, input logic [31:0] data,
		output logic [31:0] rsp);
		int cnt;
		@(posedge clk);
		cmdReq <= 1'b1;
		cmdOp <= op;
		cmdAddr <= addr;
		cmdData <= data;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (cmdAck !== 1'b1 && cnt < CMD_TIMEOUT);
		if (cmdAck !== 1'b1) timedOut($sformatf("no cmdAck for command %s", op.name()));
		rsp = rspData;
		cmdReq <= 1'b0;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (cmdAck !== 1'b0 && cnt < CMD_TIMEOUT);
		if (cmdAck !== 1'b0) timedOut($sformatf("cmdAck stuck high after %s", op.name()));
	endtask

	task automatic memWrite(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] rsp;
		hostCmd(DBG_MEM_WRITE, addr, data, rsp);
		refMem[addr[15:2] % MEM_WORDS] = data;
	endtask

	task automatic memRead(input logic [15:0] addr, output logic [31:0] data);
		hostCmd(DBG_MEM_READ, addr, '0, data);
	endtask

	task automatic waitHalted(input int limit);
		int cnt;
		cnt = 0;
		while (halted !== 1'b1 && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		if (halted !== 1'b1) timedOut("core never reached halted");
	endtask

	////////////////////////////////////////////////////////////
	// Instruction encoding and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rIns(functE fn, logic [4:0] rs, logic [4:0] rt, logic [4:0] rd);
		instrWordU w;
		w = '0;
		w.r.op = OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic logic [31:0] iIns(opcodeE op, logic [4:0] rs, logic [4:0] rt, logic [15:0] imm);
		instrWordU w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	task automatic setReg(input logic [4:0] idx, input logic [31:0] val);
		// Writes to r0 are dropped
		if (idx != 5'd0) refRegs[idx] = val;
	endtask

	// One instruction by the ISA rules, BREAK keeps the PC
	task automatic refStep(output logic brk);
		instrWordU ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] nextPc;
		ins = refMem[refPc[15:2] % MEM_WORDS];
		a = refRegs[ins.r.rs];
		b = refRegs[ins.r.rt];
		sext = {{16{ins.i.imm[15]}}, ins.i.imm};
		nextPc = refPc + 32'd4;
		brk = 1'b0;
		case (ins.r.op)
			OP_RTYPE: begin
				case (ins.r.funct)
					FN_ADDU: setReg(ins.r.rd, a + b);
					FN_SUBU: setReg(ins.r.rd, a - b);
					FN_AND: setReg(ins.r.rd, a & b);
					FN_OR: setReg(ins.r.rd, a | b);
					FN_SLT: setReg(ins.r.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					FN_BREAK: brk = 1'b1;
					default: ;
				endcase
			end
			OP_ADDIU: setReg(ins.i.rt, a + sext);
			OP_LW: setReg(ins.i.rt, refMem[((a + sext) >> 2) % MEM_WORDS]);
			OP_SW: refMem[((a + sext) >> 2) % MEM_WORDS] = b;
			// Branch target from PC+4, offset in words
			OP_BEQ: if (a == b) nextPc = refPc + 32'd4 + (sext << 2);
			default: ;
		endcase
		if (!brk) refPc = nextPc;
	endtask

	task automatic refRunToBreak();
		logic brk;
		int n;
		brk = 1'b0;
		n = 0;
		while (!brk && n < 5000) begin
			refStep(brk);
			n++;
		end
		if (!brk) timedOut("reference model never reached BREAK");
	endtask

	// PC and every register against the model
	task automatic compareState(input string tag);
		logic [31:0] got;
		hostCmd(DBG_PC_READ, '0, '0, got);
		checkWord({tag, " pc"}, refPc, got);
		for (int k = 0; k < 32; k++) begin
			hostCmd(DBG_REG_READ, 16'(k), '0, got);
			checkWord($sformatf("%s r%0d", tag, k), refRegs[k], got);
		end
	endtask

	// Arithmetic, logic, a store loop and a load, then BREAK at 0x48
	task automatic loadProgram();
		logic [31:0] prog [$];
		prog.push_back(iIns(OP_ADDIU, 5'd0, 5'd0, 16'd7));
		prog.push_back(iIns(OP_ADDIU, 5'd0, 5'd1, 16'd5));
		prog.push_back(iIns(OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
		prog.push_back(rIns(FN_ADDU, 5'd1, 5'd2, 5'd3));
		prog.push_back(rIns(FN_SUBU, 5'd1, 5'd2, 5'd4));
		prog.push_back(rIns(FN_AND, 5'd1, 5'd4, 5'd5));
		prog.push_back(rIns(FN_OR, 5'd1, 5'd4, 5'd6));
		prog.push_back(rIns(FN_SLT, 5'd2, 5'd1, 5'd7));
		prog.push_back(rIns(FN_SLT, 5'd1, 5'd2, 5'd8));
		prog.push_back(iIns(OP_ADDIU, 5'd0, 5'd9, 16'h0200));
		prog.push_back(iIns(OP_ADDIU, 5'd0, 5'd10, 16'd0));
		// Loop body at 0x2c
		prog.push_back(rIns(FN_ADDU, 5'd10, 5'd1, 5'd10));
		prog.push_back(iIns(OP_ADDIU, 5'd1, 5'd1, 16'hffff));
		prog.push_back(iIns(OP_SW, 5'd9, 5'd10, 16'd0));
		prog.push_back(iIns(OP_ADDIU, 5'd9, 5'd9, 16'd4));
		prog.push_back(iIns(OP_BEQ, 5'd1, 5'd0, 16'd1));
		prog.push_back(iIns(OP_BEQ, 5'd0, 5'd0, 16'hfffa));
		prog.push_back(iIns(OP_LW, 5'd9, 5'd11, 16'hfffc));
		prog.push_back(rIns(FN_BREAK, 5'd0, 5'd0, 5'd0));
		foreach (prog[k]) memWrite(16'(k * 4), prog[k]);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rsp;
		logic [31:0] data;
		logic [15:0] addr;
		logic brk;
		int cnt;
		cmdReq <= 1'b0;
		cmdOp <= DBG_PC_READ;
		cmdAddr <= '0;
		cmdData <= '0;
		// Unreset registers start unknown, r0 is zero
		foreach (refRegs[k]) refRegs[k] = 'x;
		refRegs[0] = '0;
		refPc = '0;
		cnt = 0;
		while (arstN !== 1'b1 && cnt < 100) begin
			@(posedge clk);
			cnt++;
		end
		if (arstN !== 1'b1) timedOut("reset never released");
		@(posedge clk);

		// Reset state
		checkWord("cmdAck", 32'd0, {31'd0, cmdAck});
		checkWord("halted", 32'd1, {31'd0, halted});
		hostCmd(DBG_PC_READ, '0, '0, rsp);
		checkWord("pc after reset", 32'd0, rsp);
		hostCmd(DBG_REG_READ, 16'd0, '0, rsp);
		checkWord("r0 after reset", 32'd0, rsp);

		// Random words in the upper quarter, clear of the program
		for (int k = 0; k < 12; k++) begin
			addr = 16'((192 + ($random(seed) & 63)) * 4);
			memWrite(addr, $random(seed));
		end
		for (int k = 192; k < MEM_WORDS; k++) begin
			if (refMem[k] !== 'x) begin
				memRead(16'(k * 4), rsp);
				checkWord($sformatf("mem[%h]", k * 4), refMem[k], rsp);
			end
		end

		// Two single steps, the first writes r0
		loadProgram();
		for (int k = 0; k < 2; k++) begin
			refStep(brk);
			hostCmd(DBG_STEP, '0, '0, rsp);
			compareState($sformatf("step %0d", k));
		end

		// Run the rest to BREAK
		refRunToBreak();
		hostCmd(DBG_RUN, '0, '0, rsp);
		waitHalted(RUN_TIMEOUT);
		compareState("break");
		for (int k = 0; k < MEM_WORDS; k++) begin
			memRead(16'(k * 4), rsp);
			checkWord($sformatf("mem[%h]", k * 4), refMem[k], rsp);
		end

		// Tight loop on the BREAK slot, host access competes with fetches
		memWrite(16'h0048, iIns(OP_BEQ, 5'd0, 5'd0, 16'hffff));
		hostCmd(DBG_RUN, '0, '0, rsp);
		checkWord("halted while running", 32'd0, {31'd0, halted});
		data = $random(seed);
		memWrite(16'h03f0, data);
		memRead(16'h03f0, rsp);
		checkWord("mem[3f0] during run", data, rsp);
		hostCmd(DBG_HALT, '0, '0, rsp);
		checkWord("halted after HALT", 32'd1, {31'd0, halted});
		hostCmd(DBG_PC_READ, '0, '0, rsp);
		checkWord("pc in loop", 32'h48, rsp);

		finishRun();
	end

endmodule

`default_nettype wire

//--- mipsDebugTop.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDebugTop import mipsPkg::*, debugPkg::*; #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic arstN,
	// Host command port, four-phase
	input logic cmdReq,
	input dbgOpE cmdOp,
	input logic [ADDR_BITS-1:0] cmdAddr,
	input logic [WORD_BITS-1:0] cmdData,
	output logic cmdAck,
	output logic [WORD_BITS-1:0] rspData,
	output logic halted
);

	// Debug and core channels into the arbiter, one out to memory
	memBus dbgMem ();
	memBus coreMem ();
	memBus memPort ();
	coreDebugIf coreDbg ();

	assign halted = coreDbg.halted;

	debugUnit debug0 (
		.clk(clk),
		.arstN(arstN),
		.cmdReq(cmdReq),
		.cmdOp(cmdOp),
		.cmdAddr(cmdAddr),
		.cmdData(cmdData),
		.cmdAck(cmdAck),
		.rspData(rspData),
		.mem(dbgMem.requester),
		.core(coreDbg.debug)
	);

	cpuCore core0 (
		.clk(clk),
		.arstN(arstN),
		.mem(coreMem.requester),
		.dbg(coreDbg.core)
	);

	memArbiter arb0 (
		.clk(clk),
		.arstN(arstN),
		.dbgPort(dbgMem.responder),
		.corePort(coreMem.responder),
		.memPort(memPort.requester)
	);

	unifiedMemory #(
		.memWords(memWords)
	) mem0 (
		.clk(clk),
		.arstN(arstN),
		.port(memPort.responder)
	);

endmodule

`default_nettype wire

//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////

	localparam int WORD_BITS = 32;
	// Register index, 32 registers
	localparam int REG_ADDR_BITS = 5;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDIU = 6'h09,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcodeE;

	// Function field of R-type, bits 5:0
	typedef enum logic [5:0] {
		FN_BREAK = 6'h0d,
		FN_ADDU  = 6'h21,
		FN_SUBU  = 6'h23,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_SLT   = 6'h2a
	} functE;

	// Same instruction word, register or immediate view
	typedef union packed {
		struct packed {
			opcodeE op;
			logic [REG_ADDR_BITS-1:0] rs;
			logic [REG_ADDR_BITS-1:0] rt;
			logic [REG_ADDR_BITS-1:0] rd;
			logic [4:0] shamt;
			functE funct;
		} r;
		struct packed {
			opcodeE op;
			logic [REG_ADDR_BITS-1:0] rs;
			logic [REG_ADDR_BITS-1:0] rt;
			logic [15:0] imm;
		} i;
	} instrWordU;

endpackage

`default_nettype wire

//--- sim.f
mipsPkg.sv
debugPkg.sv
memBus.sv
coreDebugIf.sv
unifiedMemory.sv
memArbiter.sv
cpuCore.sv
debugUnit.sv
mipsDebugTop.sv
tbClock.sv
mipsDebugTb.sv

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset
module tbClock #(
	parameter int resetCycles = 8
) (
	output logic clk,
	output logic arstN
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Released on a rising edge
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

//--- unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory import mipsPkg::*; #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic arstN,
	memBus.responder port
);

	// Word index width
	localparam int IDX_BITS = $clog2(memWords);

	logic [WORD_BITS-1:0] mem [memWords];
	logic [WORD_BITS-1:0] rdataQ;
	logic [IDX_BITS-1:0] idx;
	logic ackQ;
	logic start;

	// Byte address to word index, low two bits dropped
	assign idx = port.addr[IDX_BITS+1:2];
	// Fresh request, ack still low
	assign start = port.req && !ackQ;

	// Ack one cycle after req, release one cycle after req falls
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ackQ <= 1'b0;
		end else if (start) begin
			ackQ <= 1'b1;
		end else if (!port.req && ackQ) begin
			ackQ <= 1'b0;
		end
	end

	// Array and read data
	always_ff @(posedge clk) begin
		if (start) begin
			if (port.we) begin
				mem[idx] <= port.wdata;
				// Write echoes the stored word
				rdataQ <= port.wdata;
			end else begin
				rdataQ <= mem[idx];
			end
		end
	end

	assign port.ack = ackQ;
	assign port.rdata = rdataQ;

endmodule

`default_nettype wire
